/* common/alut_tbl_pkg.sv */
/*
 * address lookup table definitions
 * table geometry, entry layout and the FSM state encodings
 * shared by the table memory and both checkers
 */

package alut_tbl_pkg;

   // --------------------------------------------------
   // geometry
   // --------------------------------------------------
   localparam int mac_w     = 48;          // station address
   localparam int port_w    = 2;           // four switch ports
   localparam int time_w    = 32;          // timestamp and age limit
   localparam int hash_w    = 8;           // table index
   localparam int tbl_depth = 256;         // 2**hash_w entries

   // one table entry, 83 bits
   typedef struct packed {
      logic              valid;            // entry in use
      logic [port_w-1:0] port;             // port the station was seen on
      logic [time_w-1:0] stamp;            // time of last learn
      logic [mac_w-1:0]  mac;              // full address, compared on lookup
   } alut_entry_t;

   // --------------------------------------------------
   // FSM states
   // --------------------------------------------------
   typedef enum logic [2:0] {
      addr_idle,                           // waiting for a request
      addr_learn,                          // write source entry
      addr_lookup,                         // issue destination read
      addr_wait_data,                      // compare returned entry
      addr_respond                         // hold response until taken
   } addr_state_t;

   typedef enum logic [2:0] {
      age_idle,                            // waiting for age_start
      age_wait_free,                       // address checker still busy
      age_read,                            // issue read of current index
      age_check,                           // test entry against max age
      age_write,                           // write back invalidated entry
      age_finish                           // done pulse, result valid
   } age_state_t;

endpackage

/* common/alut_io_pkg.sv */
/*
 * subsystem port types
 * lookup request and response, and the result of an aging sweep
 */

package alut_io_pkg;

   import alut_tbl_pkg::*;

   // removed count covers 0..tbl_depth, hence one extra bit
   localparam int cnt_w = hash_w + 1;

   // one frame header as seen by the table
   typedef struct packed {
      logic [mac_w-1:0]  src_mac;          // learned against src_port
      logic [mac_w-1:0]  dst_mac;          // looked up
      logic [port_w-1:0] src_port;         // ingress port
   } lookup_req_t;

   // lookup result
   typedef struct packed {
      logic              hit;              // 0 means flood
      logic [port_w-1:0] port;             // egress port on hit
   } lookup_rsp_t;

   // --------------------------------------------------
   // aging result
   // --------------------------------------------------
   typedef struct packed {
      logic [cnt_w-1:0]  removed;          // entries cleared by the sweep
   } age_stat_t;

endpackage

/* alut/alut_mem.sv */
/*
 * address table memory
 * two independent ports, each does one read or one write per clock
 * read data is registered, no reset on the array or outputs
 */

`timescale 1ns/1ns

module alut_mem
   import alut_tbl_pkg::*;
(
   input  logic              pclk22,
   // port a, address checker
   input  logic [hash_w-1:0] addr_a,
   input  logic              write_a,      // high = write, low = read
   input  alut_entry_t       wdata_a,
   // port b, age checker
   input  logic [hash_w-1:0] addr_b,
   input  logic              write_b,      // high = write, low = read
   input  alut_entry_t       wdata_b,
   output alut_entry_t       rdata_a,
   output alut_entry_t       rdata_b
);

   alut_entry_t mem_array [tbl_depth];     // table storage

   // --------------------------------------------------
   // port a
   // --------------------------------------------------
   always @(posedge pclk22)
   begin
      if (write_a)
      begin
         mem_array[addr_a] <= wdata_a;     // learn
      end
      else
      begin
         rdata_a <= mem_array[addr_a];     // lookup read
      end
   end

   // --------------------------------------------------
   // port b
   // --------------------------------------------------
   always @(posedge pclk22)
   begin
      if (write_b)
      begin
         mem_array[addr_b] <= wdata_b;     // invalidate stale entry
      end
      else
      begin
         rdata_b <= mem_array[addr_b];     // sweep read
      end
   end

endmodule

/* alut/alut_addr_check.sv */
/*
 * address checker
 * per request: learn source address on its ingress port,
 * then read destination entry and return hit/port or miss
 */

`timescale 1ns/1ns

module alut_addr_check
   import alut_tbl_pkg::*;
   import alut_io_pkg::*;
(
   input  logic              pclk22,
   input  logic              rst_n,
   input  lookup_req_t       req,
   input  logic              req_valid,
   output logic              req_ready,
   output lookup_rsp_t       rsp,
   output logic              rsp_valid,
   input  logic              rsp_ready,
   input  logic              age_busy,     // sweep in progress, hold off
   input  logic [time_w-1:0] now,          // learn timestamp
   output logic              addr_busy,
   // table port
   output logic [hash_w-1:0] addr,
   output logic              write,
   output alut_entry_t       wdata,
   input  alut_entry_t       rdata
);

   addr_state_t state;
   lookup_req_t req_q;                     // request being served
   logic        req_take;                  // request transfer this cycle
   logic        rsp_take;                  // response transfer this cycle
   logic        dst_hit;

   // xor of the address bytes
   function automatic logic [hash_w-1:0] mac_hash(input logic [mac_w-1:0] mac);
      logic [hash_w-1:0] h;
      h = '0;
      for (int i = 0; i < mac_w / hash_w; i++)
      begin
         h ^= mac[i*hash_w +: hash_w];
      end
      return h;
   endfunction

   // --------------------------------------------------
   // handshakes
   // --------------------------------------------------
   assign req_ready = (state == addr_idle) && !age_busy;   // one in flight
   assign req_take  = req_valid && req_ready;
   assign rsp_valid = (state == addr_respond);
   assign rsp_take  = rsp_valid && rsp_ready;
   assign addr_busy = (state != addr_idle);

   // table port, driven from the latched request
   assign write      = (state == addr_learn);
   assign addr       = write ? mac_hash(req_q.src_mac) : mac_hash(req_q.dst_mac);
   assign wdata.valid = 1'b1;
   assign wdata.port  = req_q.src_port;
   assign wdata.stamp = now;
   assign wdata.mac   = req_q.src_mac;

   // destination entry must match the full address
   assign dst_hit = rdata.valid && (rdata.mac == req_q.dst_mac);

   // --------------------------------------------------
   // control
   // --------------------------------------------------
   always_ff @(posedge pclk22 or negedge rst_n)
   begin
      if (!rst_n)
      begin
         state <= addr_idle;
      end
      else
      begin
         case (state)
            addr_idle:
            begin
               if (req_take)
               begin
                  state <= addr_learn;
               end
            end
            addr_learn:     state <= addr_lookup;     // write lands here
            addr_lookup:    state <= addr_wait_data;  // read issued
            addr_wait_data: state <= addr_respond;    // rsp captured
            addr_respond:
            begin
               if (rsp_take)
               begin
                  state <= addr_idle;
               end
            end
            default:        state <= addr_idle;
         endcase
      end
   end

   // payload, no reset needed
   always_ff @(posedge pclk22)
   begin
      if (req_take)
      begin
         req_q <= req;
      end
      if (state == addr_wait_data)
      begin
         rsp.hit  <= dst_hit;
         rsp.port <= dst_hit ? rdata.port : '0;   // port is don't care on miss
      end
   end

endmodule

/* alut/alut_age_check.sv */
/*
 * age checker
 * free running time base, plus an on-demand sweep of the table
 * that clears valid entries older than max_age and counts them
 */

`timescale 1ns/1ns

module alut_age_check
   import alut_tbl_pkg::*;
   import alut_io_pkg::*;
(
   input  logic              pclk22,
   input  logic              rst_n,
   input  logic              age_start,    // one-cycle command
   input  logic [time_w-1:0] max_age,
   input  logic              addr_busy,    // address checker mid-request
   output logic              age_busy,
   output logic              age_done,     // one-cycle pulse
   output age_stat_t         age_stat,     // held until next done
   output logic [time_w-1:0] now,
   // table port
   output logic [hash_w-1:0] addr,
   output logic              write,
   output alut_entry_t       wdata,
   input  alut_entry_t       rdata
);

   age_state_t        state;
   logic [hash_w-1:0] idx;                 // sweep position
   logic [cnt_w-1:0]  removed_cnt;
   logic [time_w-1:0] max_q;               // limit for this sweep
   logic [time_w-1:0] age_diff;
   logic              stale;
   logic              last_idx;
   alut_entry_t       wdata_q;             // entry to write back

   // --------------------------------------------------
   // time base
   // --------------------------------------------------
   always_ff @(posedge pclk22 or negedge rst_n)
   begin
      if (!rst_n)
      begin
         now <= '0;
      end
      else
      begin
         now <= now + 1'b1;                // wraps, difference still valid
      end
   end

   assign age_diff = now - rdata.stamp;
   assign stale    = rdata.valid && (age_diff > max_q);
   assign last_idx = (idx == hash_w'(tbl_depth - 1));

   assign age_busy = (state != age_idle);
   assign age_done = (state == age_finish);
   assign addr     = idx;
   assign write    = (state == age_write);
   assign wdata    = wdata_q;

   // --------------------------------------------------
   // sweep FSM
   // --------------------------------------------------
   always_ff @(posedge pclk22 or negedge rst_n)
   begin
      if (!rst_n)
      begin
         state       <= age_idle;
         idx         <= '0;
         removed_cnt <= '0;
         age_stat    <= '0;
      end
      else
      begin
         case (state)
            age_idle:
            begin
               if (age_start)
               begin
                  idx         <= '0;
                  removed_cnt <= '0;
                  state       <= age_wait_free;
               end
            end
            age_wait_free:
            begin
               if (!addr_busy)
               begin
                  state <= age_read;
               end
            end
            age_read: state <= age_check;        // rdata valid next
            age_check:
            begin
               if (stale)
               begin
                  removed_cnt <= removed_cnt + 1'b1;
                  state       <= age_write;
               end
               else if (last_idx)
               begin
                  age_stat.removed <= removed_cnt;
                  state            <= age_finish;
               end
               else
               begin
                  idx   <= idx + 1'b1;
                  state <= age_wait_free;
               end
            end
            age_write:
            begin
               if (last_idx)
               begin
                  age_stat.removed <= removed_cnt;   // already counted
                  state            <= age_finish;
               end
               else
               begin
                  idx   <= idx + 1'b1;
                  state <= age_wait_free;
               end
            end
            age_finish: state <= age_idle;
            default:    state <= age_idle;
         endcase
      end
   end

   // payload, no reset needed
   always_ff @(posedge pclk22)
   begin
      if ((state == age_idle) && age_start)
      begin
         max_q <= max_age;
      end
      if (state == age_check)
      begin
         // keep port, stamp and mac, drop valid
         wdata_q <= '{valid: 1'b0, port: rdata.port, stamp: rdata.stamp, mac: rdata.mac};
      end
   end

endmodule

/* src/alut_top.sv */
/*
 * address lookup table top
 * address checker and age checker share one dual-port table
 */

`timescale 1ns/1ns

module alut_top
   import alut_tbl_pkg::*;
   import alut_io_pkg::*;
(
   input  logic              pclk22,
   input  logic              rst_n,
   // lookup path
   input  lookup_req_t       req,
   input  logic              req_valid,
   output logic              req_ready,
   output lookup_rsp_t       rsp,
   output logic              rsp_valid,
   input  logic              rsp_ready,
   // aging path
   input  logic              age_start,
   input  logic [time_w-1:0] max_age,
   output logic              age_done,
   output age_stat_t         age_stat
);

   // --------------------------------------------------
   // internal wires
   // --------------------------------------------------
   logic [hash_w-1:0] addr_a;              // port a, address checker
   logic              write_a;
   alut_entry_t       wdata_a;
   alut_entry_t       rdata_a;
   logic [hash_w-1:0] addr_b;              // port b, age checker
   logic              write_b;
   alut_entry_t       wdata_b;
   alut_entry_t       rdata_b;
   logic [time_w-1:0] now;
   logic              addr_busy;           // mutual exclusion pair
   logic              age_busy;

   alut_addr_check addr_check_i (
      .pclk22    (pclk22),
      .rst_n     (rst_n),
      .req       (req),
      .req_valid (req_valid),
      .req_ready (req_ready),
      .rsp       (rsp),
      .rsp_valid (rsp_valid),
      .rsp_ready (rsp_ready),
      .age_busy  (age_busy),
      .now       (now),
      .addr_busy (addr_busy),
      .addr      (addr_a),
      .write     (write_a),
      .wdata     (wdata_a),
      .rdata     (rdata_a)
   );

   alut_age_check age_check_i (
      .pclk22    (pclk22),
      .rst_n     (rst_n),
      .age_start (age_start),
      .max_age   (max_age),
      .addr_busy (addr_busy),
      .age_busy  (age_busy),
      .age_done  (age_done),
      .age_stat  (age_stat),
      .now       (now),
      .addr      (addr_b),
      .write     (write_b),
      .wdata     (wdata_b),
      .rdata     (rdata_b)
   );

   alut_mem mem_i (
      .pclk22  (pclk22),
      .addr_a  (addr_a),
      .write_a (write_a),
      .wdata_a (wdata_a),
      .addr_b  (addr_b),
      .write_b (write_b),
      .wdata_b (wdata_b),
      .rdata_a (rdata_a),
      .rdata_b (rdata_b)
   );

endmodule

/* sim/alut_checker.sv */
/*
 * protocol assertions for the lookup table top
 * bound into alut_top, watches both handshakes
 */

`timescale 1ns/1ns

module alut_checker
   import alut_io_pkg::*;
(
   input logic        pclk22,
   input logic        rst_n,
   input logic        req_valid,
   input logic        req_ready,
   input lookup_rsp_t rsp,
   input logic        rsp_valid,
   input logic        rsp_ready,
   input logic        age_start,
   input logic        age_done
);

   logic sweep_on;                   // after age_start, up to age_done

   // sweep window seen from the ports only
   always_ff @(posedge pclk22 or negedge rst_n)
   begin
      if (!rst_n)
      begin
         sweep_on <= 1'b0;
      end
      else if (age_done)
      begin
         sweep_on <= 1'b0;           // start in the done cycle is ignored
      end
      else if (age_start)
      begin
         sweep_on <= 1'b1;
      end
   end

   // --------------------------------------------------
   // lookup path
   // --------------------------------------------------
   rsp_hold_a: assert property (@(posedge pclk22) disable iff (!rst_n)
      rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp))
      else $error("response dropped or changed under back-pressure");

   // table owned by the sweep, same-cycle request still allowed
   no_req_in_sweep_a: assert property (@(posedge pclk22) disable iff (!rst_n)
      req_valid && req_ready |-> !sweep_on)
      else $error("request accepted during an aging sweep");

   // --------------------------------------------------
   // aging path
   // --------------------------------------------------
   done_pulse_a: assert property (@(posedge pclk22) disable iff (!rst_n)
      age_done |=> !age_done)
      else $error("age_done longer than one cycle");

   reset_quiet_a: assert property (@(posedge pclk22)
      !rst_n |-> !rsp_valid && !age_done)
      else $error("rsp_valid or age_done high in reset");

endmodule

bind alut_top alut_checker checker_i (
   .pclk22    (pclk22),
   .rst_n     (rst_n),
   .req_valid (req_valid),
   .req_ready (req_ready),
   .rsp       (rsp),
   .rsp_valid (rsp_valid),
   .rsp_ready (rsp_ready),
   .age_start (age_start),
   .age_done  (age_done)
);

/* sim/alut_tb.sv */
/*
 * testbench for the address lookup table
 * seeded random requests and aging sweeps, checked against a table model
 */

`timescale 1ns/1ns

module alut_tb
   import alut_tbl_pkg::*;
   import alut_io_pkg::*;
();

   localparam int pool_size = 12;
   // 5 sweeps of ~1030 cycles, ~330 requests of up to ~15 cycles, gaps, x2 margin
   localparam int timeout_cycles = 20000;

   logic              pclk22;
   logic              rst_n;
   lookup_req_t       req;
   logic              req_valid;
   logic              req_ready;
   lookup_rsp_t       rsp;
   logic              rsp_valid;
   logic              rsp_ready;
   logic              age_start;
   logic [time_w-1:0] max_age;
   logic              age_done;
   age_stat_t         age_stat;

   // --------------------------------------------------
   // reference model
   // --------------------------------------------------
   logic              mdl_valid [tbl_depth];
   logic [mac_w-1:0]  mdl_mac   [tbl_depth];
   logic [port_w-1:0] mdl_port  [tbl_depth];
   logic [mac_w-1:0]  pool      [pool_size];    // station addresses in use

   int          check_cnt;                      // checks run
   int          fail_cnt;                       // checks failed
   int          test_err;                       // failures in current test
   int          cycle_cnt;
   int unsigned seed_dummy;

   alut_top dut_i (
      .pclk22    (pclk22),
      .rst_n     (rst_n),
      .req       (req),
      .req_valid (req_valid),
      .req_ready (req_ready),
      .rsp       (rsp),
      .rsp_valid (rsp_valid),
      .rsp_ready (rsp_ready),
      .age_start (age_start),
      .max_age   (max_age),
      .age_done  (age_done),
      .age_stat  (age_stat)
   );

   initial
   begin
      pclk22 = 1'b0;
      forever #4 pclk22 = ~pclk22;              // 8 ns period
   end

   // run limit
   always @(posedge pclk22)
   begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= timeout_cycles)
      begin
         $display("run stopped, tests did not finish within %0d cycles", timeout_cycles);
         $display("STATUS: FAIL");
         $finish;
      end
   end

   // xor fold of the six address bytes
   function automatic logic [hash_w-1:0] idx_of(input logic [mac_w-1:0] mac);
      return mac[47:40] ^ mac[39:32] ^ mac[31:24] ^ mac[23:16] ^ mac[15:8] ^ mac[7:0];
   endfunction

   function automatic logic [mac_w-1:0] random_mac();
      logic [31:0] hi;
      logic [31:0] lo;
      hi = $urandom;
      lo = $urandom;
      return {hi[15:0], lo};
   endfunction

   function automatic logic [mac_w-1:0] pool_mac();
      return pool[$urandom_range(pool_size - 1)];
   endfunction

   function automatic void clear_model();
      for (int i = 0; i < tbl_depth; i++)
      begin
         mdl_valid[i] = 1'b0;
      end
   endfunction

   function automatic int valid_count();
      int n;
      n = 0;
      for (int i = 0; i < tbl_depth; i++)
      begin
         n += int'(mdl_valid[i]);
      end
      return n;
   endfunction

   task automatic end_test(input string name);
      $display("test %-10s done, %0d errors", name, test_err);
      test_err = 0;
   endtask

   // --------------------------------------------------
   // one request, entered and left on a falling edge
   // --------------------------------------------------
   task automatic do_request(input string name, input logic [mac_w-1:0] src,
                             input logic [mac_w-1:0] dst, input logic [port_w-1:0] sport);
      logic [hash_w-1:0] si;
      logic [hash_w-1:0] di;
      logic              exp_hit;
      logic [port_w-1:0] exp_port;
      lookup_rsp_t       got;
      req       = '{src_mac: src, dst_mac: dst, src_port: sport};
      req_valid = 1'b1;
      while (!req_ready)
      begin
         @(negedge pclk22);                     // held off by a sweep
      end
      @(posedge pclk22);                        // transfer
      // learn first, so src equal to dst hits
      si            = idx_of(src);
      mdl_valid[si] = 1'b1;
      mdl_mac[si]   = src;
      mdl_port[si]  = sport;
      di            = idx_of(dst);
      exp_hit       = mdl_valid[di] && (mdl_mac[di] == dst);
      exp_port      = mdl_port[di];
      @(negedge pclk22);
      req_valid = 1'b0;
      rsp_ready = 1'($urandom_range(1));        // random back-pressure
      while (!(rsp_valid && rsp_ready))
      begin
         @(negedge pclk22);
         rsp_ready = 1'($urandom_range(1));
      end
      got = rsp;                                // taken at the next rising edge
      @(negedge pclk22);
      rsp_ready = 1'b0;
      check_cnt++;
      if (got.hit !== exp_hit)
      begin
         $display("Fail %s: hit expected %0b, actual %0b (dst %h)", name, exp_hit, got.hit, dst);
         fail_cnt++;
         test_err++;
      end
      else if (exp_hit && (got.port !== exp_port))
      begin
         $display("Fail %s: port expected %0d, actual %0d (dst %h)", name, exp_port, got.port,
                  dst);
         fail_cnt++;
         test_err++;
      end
   endtask

   // --------------------------------------------------
   // one aging sweep
   // --------------------------------------------------
   task automatic do_sweep(input string name, input logic [time_w-1:0] limit,
                           input bit check_on);
      int exp_removed;
      max_age   = limit;
      age_start = 1'b1;
      @(negedge pclk22);
      age_start = 1'b0;
      while (!age_done)
      begin
         @(negedge pclk22);
      end
      // limit 0, every learned entry is already older
      exp_removed = (limit == 0) ? valid_count() : 0;
      if (check_on)
      begin
         check_cnt++;
         if (age_stat.removed !== cnt_w'(exp_removed))
         begin
            $display("Fail %s: removed expected %0d, actual %0d", name, exp_removed,
                     age_stat.removed);
            fail_cnt++;
            test_err++;
         end
      end
      if (limit == 0)
      begin
         clear_model();
      end
      @(negedge pclk22);
   endtask

   // fresh sources, so only a pool destination could ever hit
   task automatic fresh_lookups(input string name, input int n);
      for (int i = 0; i < n; i++)
      begin
         do_request(name, random_mac(), pool_mac(), 2'($urandom_range(3)));
      end
   endtask

   // --------------------------------------------------
   // test sequence
   // --------------------------------------------------
   initial
   begin
      seed_dummy = $urandom(32'h89a2);          // single seed for the run
      rst_n      = 1'b1;
      req        = '0;
      req_valid  = 1'b0;
      rsp_ready  = 1'b0;
      age_start  = 1'b0;
      max_age    = '0;
      clear_model();
      for (int i = 0; i < pool_size - 1; i++)
      begin
         pool[i] = random_mac();
      end
      pool[pool_size-1] = pool[0] ^ 48'h0000_0505_0000;   // same hash as pool[0]
      @(negedge pclk22);
      rst_n = 1'b0;
      repeat (8) @(negedge pclk22);
      rst_n = 1'b1;
      @(negedge pclk22);

      // define pool indices, then sweep them out, count undefined here
      for (int i = 0; i < pool_size; i++)
      begin
         do_request("prime", pool[i], pool[i], 2'(i));
      end
      do_sweep("prime", '0, 1'b0);
      end_test("prime");

      fresh_lookups("cleared", 20);
      end_test("cleared");

      for (int i = 0; i < 200; i++)
      begin
         do_request("learn", pool_mac(), pool_mac(), 2'($urandom_range(3)));
      end
      end_test("learn");

      do_sweep("no_aging", '1, 1'b1);
      for (int i = 0; i < 20; i++)
      begin
         do_request("no_aging", pool_mac(), pool_mac(), 2'($urandom_range(3)));
      end
      end_test("no_aging");

      do_sweep("age_all", '0, 1'b1);
      fresh_lookups("age_all", 20);
      end_test("age_all");

      fork
         begin
            for (int i = 0; i < 60; i++)
            begin
               repeat ($urandom_range(6)) @(negedge pclk22);
               do_request("concurrent", pool_mac(), pool_mac(), 2'($urandom_range(3)));
            end
         end
         begin
            logic [time_w-1:0] lim;
            for (int s = 0; s < 2; s++)
            begin
               repeat ($urandom_range(200)) @(negedge pclk22);
               lim = $urandom_range(1) ? '1 : '0;   // keep all or drop all
               do_sweep("concurrent", lim, 1'b1);
            end
         end
      join
      end_test("concurrent");

      $display("checks run %0d, passed %0d, failed %0d", check_cnt, check_cnt - fail_cnt,
               fail_cnt);
      if (fail_cnt == 0)
      begin
         $display("STATUS: PASS");
      end
      else
      begin
         $display("STATUS: FAIL");
      end
      $finish;
   end

endmodule

/* compile.f */
common/alut_tbl_pkg.sv
common/alut_io_pkg.sv
alut/alut_mem.sv
alut/alut_addr_check.sv
alut/alut_age_check.sv
src/alut_top.sv
sim/alut_checker.sv
sim/alut_tb.sv

/* Bender.yml */
package:
  name: alut

sources:
  # packages first, then the table and both checkers
  - common/alut_tbl_pkg.sv
  - common/alut_io_pkg.sv
  - alut/alut_mem.sv
  - alut/alut_addr_check.sv
  - alut/alut_age_check.sv
  - src/alut_top.sv
  - target: simulation
    files:
      - sim/alut_checker.sv
      - sim/alut_tb.sv
